// ==== common/mrp_pkg.sv ====
package mrp_pkg;

    // connection table sizing.
    localparam int num_conns   = 16;
    localparam int conn_id_w   = $clog2(num_conns);
    localparam int timestamp_w = 32;

    // expiry event buffering.
    localparam int fifo_depth = 4;
    localparam int fifo_ptr_w = $clog2(fifo_depth);

    localparam int closed_count_w = 16;

    typedef struct packed {
        logic [31:0] remote_addr;
        logic [15:0] remote_port;
        logic [15:0] local_port;
    } conn_key_t;

    // one host command, set and clear are never both high.
    typedef struct packed {
        logic                   set;
        logic                   clear;
        logic [conn_id_w-1:0]   conn_id;
        logic [timestamp_w-1:0] deadline;
        conn_key_t              key;
    } timer_cmd_t;

    typedef struct packed {
        logic [conn_id_w-1:0] conn_id;
        conn_key_t            key;
    } expiry_evt_t;

endpackage

// ==== list.f ====
common/mrp_pkg.sv
rtl/sync_ram.sv
timeout_engine/timeout_engine.sv
rtl/event_fifo.sv
rtl/close_notifier.sv
rtl/conn_timeout_top.sv
tests/tb_conn_timeout.sv

// ==== rtl/close_notifier.sv ====
module close_notifier (
     input  logic                                 clk
    ,input  logic                                 rst

    ,input  mrp_pkg::expiry_evt_t                 head
    ,input  logic                                 empty
    ,output logic                                 pop

    ,output logic                                 close_val
    ,output mrp_pkg::expiry_evt_t                 close_evt
    ,input  logic                                 close_rdy

    ,output logic [mrp_pkg::closed_count_w-1:0]   closed_count
);

    logic accept;

    assign accept = close_val & close_rdy;

    // refill when the slot is free or draining this cycle.
    assign pop = (~close_val | close_rdy) & ~empty;

    always_ff @(posedge clk) begin
        if (rst) begin
            close_val    <= 1'b0;
            closed_count <= '0;
        end
        else begin
            if (pop) begin
                close_val <= 1'b1;
            end
            else if (accept) begin
                close_val <= 1'b0;
            end
            if (accept) begin
                closed_count <= closed_count + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (pop) begin
            close_evt <= head;
        end
    end

endmodule

// ==== rtl/conn_timeout_top.sv ====
module conn_timeout_top (
     input  logic                                 clk
    ,input  logic                                 rst

    ,input  mrp_pkg::timer_cmd_t                  cmd
    ,input  logic [mrp_pkg::timestamp_w-1:0]      curr_time

    ,output logic                                 close_val
    ,output mrp_pkg::expiry_evt_t                 close_evt
    ,input  logic                                 close_rdy

    ,output logic [mrp_pkg::closed_count_w-1:0]   closed_count
);

    logic [mrp_pkg::conn_id_w-1:0] key_rd_addr;
    mrp_pkg::conn_key_t            key_rd_data;

    logic                          push;
    mrp_pkg::expiry_evt_t          push_evt;
    logic                          full;

    logic                          pop;
    mrp_pkg::expiry_evt_t          head;
    logic                          empty;

    // key table, read every cycle at the scan id.
    sync_ram #(
         .T     (mrp_pkg::conn_key_t  )
        ,.els   (mrp_pkg::num_conns   )
    ) key_table_i (
         .clk       (clk            )

        ,.w_val     (cmd.set        )
        ,.w_addr    (cmd.conn_id    )
        ,.w_data    (cmd.key        )

        ,.r_val     (1'b1           )
        ,.r_addr    (key_rd_addr    )
        ,.r_data    (key_rd_data    )
    );

    timeout_engine engine_i (
         .clk           (clk            )
        ,.rst           (rst            )

        ,.cmd           (cmd            )
        ,.curr_time     (curr_time      )

        ,.key_rd_addr   (key_rd_addr    )
        ,.key_rd_data   (key_rd_data    )

        ,.push          (push           )
        ,.push_evt      (push_evt       )
        ,.full          (full           )
    );

    event_fifo fifo_i (
         .clk       (clk        )
        ,.rst       (rst        )

        ,.push      (push       )
        ,.push_evt  (push_evt   )
        ,.full      (full       )

        ,.pop       (pop        )
        ,.head      (head       )
        ,.empty     (empty      )
    );

    close_notifier notifier_i (
         .clk           (clk            )
        ,.rst           (rst            )

        ,.head          (head           )
        ,.empty         (empty          )
        ,.pop           (pop            )

        ,.close_val     (close_val      )
        ,.close_evt     (close_evt      )
        ,.close_rdy     (close_rdy      )

        ,.closed_count  (closed_count   )
    );

endmodule

// ==== rtl/event_fifo.sv ====
module event_fifo (
     input  logic                  clk
    ,input  logic                  rst

    ,input  logic                  push
    ,input  mrp_pkg::expiry_evt_t  push_evt
    ,output logic                  full

    ,input  logic                  pop
    ,output mrp_pkg::expiry_evt_t  head
    ,output logic                  empty
);

    mrp_pkg::expiry_evt_t mem [mrp_pkg::fifo_depth];

    logic [mrp_pkg::fifo_ptr_w-1:0] wr_ptr;
    logic [mrp_pkg::fifo_ptr_w-1:0] rd_ptr;
    logic [mrp_pkg::fifo_ptr_w:0]   count;

    logic do_push;
    logic do_pop;

    assign full  = (count == (mrp_pkg::fifo_ptr_w + 1)'(mrp_pkg::fifo_depth));
    assign empty = (count == '0);
    assign head  = mem[rd_ptr];

    assign do_push = push & ~full;
    assign do_pop  = pop & ~empty;

    always_ff @(posedge clk) begin
        if (do_push) begin
            mem[wr_ptr] <= push_evt;
        end
    end

    // pointers wrap naturally since the depth is a power of two.
    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end
        else begin
            if (do_push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({do_push, do_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

endmodule

// ==== rtl/sync_ram.sv ====
module sync_ram #(
     parameter type T   = logic [31:0]
    ,parameter int  els = mrp_pkg::num_conns
)(
     input  logic                     clk

    ,input  logic                     w_val
    ,input  logic [$clog2(els)-1:0]   w_addr
    ,input  T                         w_data

    ,input  logic                     r_val
    ,input  logic [$clog2(els)-1:0]   r_addr
    ,output T                         r_data
);

    T mem [els];

    always_ff @(posedge clk) begin
        if (w_val) begin
            mem[w_addr] <= w_data;
        end
    end

    // registered read, a same-cycle write to the read address is forwarded.
    always_ff @(posedge clk) begin
        if (r_val) begin
            if (w_val && (w_addr == r_addr)) begin
                r_data <= w_data;
            end
            else begin
                r_data <= mem[r_addr];
            end
        end
    end

endmodule

// ==== tests/tb_conn_timeout.sv ====
module tb_conn_timeout;

    localparam int test_len    = 400;
    localparam int num_tests   = 6;
    localparam int cycle_limit = num_tests * test_len * 2;
    // two full scan loops at up to four cycles per armed id.
    localparam int scan_window = 2 * 4 * mrp_pkg::num_conns;

    logic                                clk;
    logic                                rst;
    mrp_pkg::timer_cmd_t                 cmd;
    logic [mrp_pkg::timestamp_w-1:0]     curr_time;
    logic                                close_val;
    mrp_pkg::expiry_evt_t                close_evt;
    logic                                close_rdy;
    logic [mrp_pkg::closed_count_w-1:0]  closed_count;

    // reference model with one entry per connection id.
    logic                                model_armed [mrp_pkg::num_conns];
    logic [mrp_pkg::timestamp_w-1:0]     model_dl    [mrp_pkg::num_conns];
    mrp_pkg::conn_key_t                  model_key   [mrp_pkg::num_conns];
    logic                                pending     [mrp_pkg::num_conns];
    logic [mrp_pkg::timestamp_w-1:0]     model_time;

    logic [31:0]                         key_state;
    logic [31:0]                         rdy_state;
    logic                                hold_rdy;
    logic                                stalled;
    mrp_pkg::expiry_evt_t                stall_evt;
    int                                  xfer_count;
    int                                  errors;
    int                                  failed_tests;
    int                                  test_err_base;
    int                                  cycle_count;

    conn_timeout_top dut_i (
         .clk           (clk            )
        ,.rst           (rst            )
        ,.cmd           (cmd            )
        ,.curr_time     (curr_time      )
        ,.close_val     (close_val      )
        ,.close_evt     (close_evt      )
        ,.close_rdy     (close_rdy      )
        ,.closed_count  (closed_count   )
    );

    initial clk = 1'b0;
    always #2 clk = ~clk;

    function automatic logic [31:0] lcg_step(input logic [31:0] s);
        return s * 32'd1103515245 + 32'd12345;
    endfunction

    function automatic logic [31:0] next_rand();
        key_state = lcg_step(key_state);
        return key_state;
    endfunction

    function automatic mrp_pkg::conn_key_t random_key();
        mrp_pkg::conn_key_t k;
        logic [31:0]        r;
        k.remote_addr = next_rand();
        r = next_rand();
        k.remote_port = r[31:16];
        r = next_rand();
        k.local_port = r[31:16];
        return k;
    endfunction

    function automatic logic [mrp_pkg::conn_id_w-1:0] pick_free_id();
        logic [31:0] r;
        r = next_rand();
        while (model_armed[r[24 +: mrp_pkg::conn_id_w]] || pending[r[24 +: mrp_pkg::conn_id_w]])
            r = next_rand();
        return r[24 +: mrp_pkg::conn_id_w];
    endfunction

    function automatic logic [mrp_pkg::timestamp_w-1:0] past_deadline();
        return model_time - 1 - (next_rand() % 64);
    endfunction

    function automatic logic [mrp_pkg::timestamp_w-1:0] future_deadline();
        return model_time + 50 + (next_rand() % 64);
    endfunction

    function automatic int count_pending();
        int n;
        n = 0;
        for (int i = 0; i < mrp_pkg::num_conns; i++) begin
            if (pending[i]) n++;
        end
        return n;
    endfunction

    task automatic report_mismatch(input string name, input logic [63:0] got,
                                   input logic [63:0] exp);
        $display("FAILED %s: got 0x%0h, expected 0x%0h", name, got, exp);
        errors++;
    endtask

    task automatic report_problem(input string msg);
        $display("error: %s", msg);
        errors++;
    endtask

    task automatic send_set(input logic [mrp_pkg::conn_id_w-1:0] id,
                            input logic [mrp_pkg::timestamp_w-1:0] deadline,
                            input mrp_pkg::conn_key_t key);
        @(posedge clk);
        cmd <= '{set: 1'b1, clear: 1'b0, conn_id: id, deadline: deadline, key: key};
        model_armed[id] = 1'b1;
        model_dl[id]    = deadline;
        model_key[id]   = key;
        pending[id]     = (deadline < model_time);
        @(posedge clk);
        cmd <= '0;
    endtask

    task automatic send_clear(input logic [mrp_pkg::conn_id_w-1:0] id);
        @(posedge clk);
        cmd <= '{set: 1'b0, clear: 1'b1, conn_id: id, deadline: '0, key: '0};
        model_armed[id] = 1'b0;
        pending[id]     = 1'b0;
        @(posedge clk);
        cmd <= '0;
    endtask

    // armed ids whose deadline drops below the new time become expected.
    task automatic set_time(input logic [mrp_pkg::timestamp_w-1:0] t);
        int i;
        @(posedge clk);
        curr_time <= t;
        model_time = t;
        for (i = 0; i < mrp_pkg::num_conns; i++) begin
            if (model_armed[i] && !pending[i] && (model_dl[i] < t)) pending[i] = 1'b1;
        end
    endtask

    task automatic wait_drained();
        int n;
        n = 0;
        @(negedge clk);
        while ((count_pending() != 0 || close_val) && n < test_len) begin
            @(negedge clk);
            n++;
        end
        if (n >= test_len) report_problem("expected close events were not all delivered in time");
    endtask

    task automatic finish_test(input string name);
        if (errors > test_err_base) begin
            failed_tests++;
            $display("test %s: failed with %0d errors", name, errors - test_err_base);
        end
        else begin
            $display("test %s: passed", name);
        end
        test_err_base = errors;
    endtask

    // random ready pattern that is forced low during the backpressure test.
    always @(posedge clk) begin
        rdy_state = lcg_step(rdy_state);
        if (hold_rdy) close_rdy <= 1'b0;
        else close_rdy <= rdy_state[20];
    end

    // the close port monitor checks each transfer against the reference model.
    always @(posedge clk) begin
        if (!rst) begin
            assert (closed_count == xfer_count[mrp_pkg::closed_count_w-1:0])
            else report_mismatch("closed_count", closed_count, xfer_count);
            if (stalled) begin
                assert (close_val && (close_evt == stall_evt))
                else report_problem("close event changed while close_rdy was low");
            end
            if (close_val) begin
                assert (pending[close_evt.conn_id])
                else report_problem($sformatf("conn %0d reported with no expiry pending",
                                              close_evt.conn_id));
            end
            if (close_val && close_rdy) begin
                assert (close_evt.key == model_key[close_evt.conn_id])
                else report_mismatch("close_evt.key", close_evt.key,
                                     model_key[close_evt.conn_id]);
                pending[close_evt.conn_id]     = 1'b0;
                model_armed[close_evt.conn_id] = 1'b0;
                xfer_count++;
            end
            stalled   = close_val && !close_rdy;
            stall_evt = close_evt;
        end
    end

    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count >= cycle_limit) begin
            $display("timeout: the run did not finish within %0d cycles", cycle_limit);
            $display("=== FAIL ===");
            $finish;
        end
    end

    initial begin
        logic [mrp_pkg::conn_id_w-1:0]   id;
        logic [mrp_pkg::timestamp_w-1:0] dl;
        mrp_pkg::conn_key_t              key2;
        int                              base;
        int                              i;
        rst           = 1'b1;
        cmd           = '0;
        curr_time     = 32'd1000;
        close_rdy     = 1'b0;
        model_time    = 32'd1000;
        key_state     = 32'd6;
        rdy_state     = 32'd6;
        hold_rdy      = 1'b0;
        stalled       = 1'b0;
        stall_evt     = '0;
        xfer_count    = 0;
        errors        = 0;
        failed_tests  = 0;
        test_err_base = 0;
        cycle_count   = 0;
        for (i = 0; i < mrp_pkg::num_conns; i++) begin
            model_armed[i] = 1'b0;
            model_dl[i]    = '0;
            model_key[i]   = '0;
            pending[i]     = 1'b0;
        end
        repeat (2) @(posedge clk);
        rst <= 1'b0;

        wait_cycles(scan_window);
        assert (!close_val) else report_mismatch("close_val", close_val, 0);
        assert (closed_count == 0) else report_mismatch("closed_count", closed_count, 0);
        finish_test("reset_idle");

        base = xfer_count;
        for (i = 0; i < 3; i++) begin
            id = pick_free_id();
            send_set(id, past_deadline(), random_key());
        end
        wait_drained();
        assert (xfer_count == base + 3) else report_mismatch("transfers", xfer_count, base + 3);
        finish_test("expired_once");

        // a deadline equal to the current time is not yet expired.
        base = xfer_count;
        id = pick_free_id();
        dl = future_deadline();
        send_set(id, dl, random_key());
        set_time(dl);
        wait_cycles(scan_window);
        assert (xfer_count == base) else report_mismatch("transfers", xfer_count, base);
        set_time(dl + 1);
        wait_drained();
        assert (xfer_count == base + 1) else report_mismatch("transfers", xfer_count, base + 1);
        finish_test("deadline_passes");

        base = xfer_count;
        id = pick_free_id();
        dl = future_deadline();
        send_set(id, dl, random_key());
        wait_cycles(8);
        send_clear(id);
        set_time(dl + 1);
        wait_cycles(scan_window);
        assert (xfer_count == base) else report_mismatch("transfers", xfer_count, base);
        finish_test("cleared_before_deadline");

        @(negedge clk);
        hold_rdy = 1'b1;
        base = xfer_count;
        for (i = 0; i < mrp_pkg::fifo_depth + 2; i++) begin
            id = pick_free_id();
            send_set(id, past_deadline(), random_key());
        end
        wait_cycles(scan_window);
        assert (close_val) else report_mismatch("close_val", close_val, 1);
        assert (closed_count == base) else report_mismatch("closed_count", closed_count, base);
        @(negedge clk);
        hold_rdy = 1'b0;
        wait_drained();
        assert (xfer_count == base + mrp_pkg::fifo_depth + 2)
        else report_mismatch("transfers", xfer_count, base + mrp_pkg::fifo_depth + 2);
        assert (closed_count == xfer_count[mrp_pkg::closed_count_w-1:0])
        else report_mismatch("closed_count", closed_count, xfer_count);
        finish_test("backpressure");

        base = xfer_count;
        id = pick_free_id();
        send_set(id, past_deadline(), random_key());
        wait_drained();
        key2 = random_key();
        send_set(id, past_deadline(), key2);
        wait_drained();
        assert (xfer_count == base + 2) else report_mismatch("transfers", xfer_count, base + 2);
        finish_test("rearm_new_key");

        $display("tests: %0d, failed: %0d, errors: %0d, transfers: %0d",
                 num_tests, failed_tests, errors, xfer_count);
        if (errors == 0) begin
            $display("=== PASS ===");
        end
        else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

    task automatic wait_cycles(input int n);
        repeat (n) @(negedge clk);
    endtask

endmodule

// ==== timeout_engine/timeout_engine.sv ====
module timeout_engine (
     input  logic                                 clk
    ,input  logic                                 rst

    ,input  mrp_pkg::timer_cmd_t                  cmd
    ,input  logic [mrp_pkg::timestamp_w-1:0]      curr_time

    ,output logic [mrp_pkg::conn_id_w-1:0]        key_rd_addr
    ,input  mrp_pkg::conn_key_t                   key_rd_data

    ,output logic                                 push
    ,output mrp_pkg::expiry_evt_t                 push_evt
    ,input  logic                                 full
);

    typedef enum logic [1:0] {
        st_bitmap  = 2'd0,
        st_read_dl = 2'd1,
        st_check   = 2'd2,
        st_output  = 2'd3
    } state_e;

    state_e state_reg;
    state_e state_next;

    logic [mrp_pkg::conn_id_w-1:0]   scan_id;
    logic                            incr_id;

    logic [mrp_pkg::num_conns-1:0]   armed;
    logic                            armed_hit;

    logic                            store_key;
    mrp_pkg::conn_key_t              key_reg;

    logic                            dl_rd_val;
    logic [mrp_pkg::timestamp_w-1:0] dl_rd_data;

    logic                            cmd_other_id;

    assign armed_hit   = armed[scan_id];
    assign key_rd_addr = scan_id;

    // a host command for another id must not race the deadline read.
    assign cmd_other_id = (cmd.set | cmd.clear) && (cmd.conn_id != scan_id);

    assign push_evt.conn_id = scan_id;
    assign push_evt.key     = key_reg;

    always_comb begin
        state_next = state_reg;
        incr_id    = 1'b0;
        store_key  = 1'b0;
        dl_rd_val  = 1'b0;
        push       = 1'b0;

        case (state_reg)
            st_bitmap: begin
                if (armed_hit) begin
                    state_next = st_read_dl;
                end
                else begin
                    incr_id = 1'b1;
                end
            end
            st_read_dl: begin
                store_key = 1'b1;
                if (!cmd_other_id) begin
                    dl_rd_val  = 1'b1;
                    state_next = st_check;
                end
            end
            st_check: begin
                // the key read is refreshed here, so a set in the previous
                // cycle carries its new key along with its new deadline.
                store_key = 1'b1;
                if (armed_hit && (dl_rd_data < curr_time)) begin
                    state_next = st_output;
                end
                else begin
                    incr_id    = 1'b1;
                    state_next = st_bitmap;
                end
            end
            st_output: begin
                if (!full) begin
                    push       = 1'b1;
                    incr_id    = 1'b1;
                    state_next = st_bitmap;
                end
            end
            default: begin
                state_next = st_bitmap;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state_reg <= st_bitmap;
            scan_id   <= '0;
        end
        else begin
            state_reg <= state_next;
            if (incr_id) begin
                scan_id <= scan_id + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (store_key) begin
            key_reg <= key_rd_data;
        end
    end

    // later assignments win, so a host set beats the expiry clear.
    always_ff @(posedge clk) begin
        if (rst) begin
            armed <= '0;
        end
        else begin
            if (push) begin
                armed[scan_id] <= 1'b0;
            end
            if (cmd.clear) begin
                armed[cmd.conn_id] <= 1'b0;
            end
            if (cmd.set) begin
                armed[cmd.conn_id] <= 1'b1;
            end
        end
    end

    sync_ram #(
         .T     (logic [mrp_pkg::timestamp_w-1:0])
        ,.els   (mrp_pkg::num_conns              )
    ) deadline_ram_i (
         .clk       (clk            )

        ,.w_val     (cmd.set        )
        ,.w_addr    (cmd.conn_id    )
        ,.w_data    (cmd.deadline   )

        ,.r_val     (dl_rd_val      )
        ,.r_addr    (scan_id        )
        ,.r_data    (dl_rd_data     )
    );

endmodule
